//--- list.f
logic/dma_map_pkg.sv
logic/dma_types_pkg.sv
logic/engine_regs.sv
logic/descriptor_ram.sv
logic/descriptor_sequencer.sv
logic/engine_stats.sv
logic/dma_engine_manager.sv
tests/tb_clock_gen.sv
tests/tb_dma_engine_manager.sv

//--- logic/descriptor_ram.sv
/*
  descriptor field RAM
  dual port table, byte strobed host port A and read only sequencer port B
*/
`timescale 1ns/1ps

module descriptor_ram
  import dma_types_pkg::*;
#(
  parameter type word_t   = logic [63:0],
  parameter int  NUM_DESC = 1024
) (
  input  logic                         CLK,
  input  desc_idx_t                    host_index,
  input  logic                         host_we,
  input  logic [$bits(word_t)/8-1:0]   host_strb,
  input  word_t                        host_data,
  output word_t                        host_rdata,
  input  desc_idx_t                    seq_index,
  output word_t                        seq_rdata
);

  localparam int IW = $clog2(NUM_DESC);
  localparam int NB = $bits(word_t) / 8;

  word_t mem [NUM_DESC];

  // port A, host side
  always_ff @(posedge CLK) begin
    if (host_we) begin
      for (int b = 0; b < NB; b++) begin
        if (host_strb[b]) mem[host_index[IW-1:0]][b*8 +: 8] <= host_data[b*8 +: 8];
      end
    end
    host_rdata <= mem[host_index[IW-1:0]];  // registered read
  end

  // port B, sequencer side
  always_ff @(posedge CLK) begin
    seq_rdata <= mem[seq_index[IW-1:0]];
  end

  // decode upstream keeps writes inside the table
  a_wr_in_range: assert property (@(posedge CLK)
    host_we |-> (32'(host_index) < NUM_DESC));

endmodule

//--- logic/descriptor_sequencer.sv
/*
  descriptor sequencer
  walks the active index through the table, latches stop and error
  and presents the current descriptor with a valid flag
*/
`timescale 1ns/1ps

module descriptor_sequencer
  import dma_types_pkg::*;
#(
  parameter int NUM_DESC = 1024
) (
  input  logic        CLK,
  input  logic        RST_N,
  input  engine_cfg_t cfg,
  input  req_status_t req,
  input  logic [63:0] addr_word,
  input  logic [63:0] size_word,
  output desc_idx_t   active_index,
  output logic        stop,
  output logic        error,
  output logic        desc_valid,
  output desc_out_t   desc
);

  localparam int IW = $clog2(NUM_DESC);

  logic [IW-1:0] idx_q;
  logic [IW-1:0] idx_d1;    // previous index, for stability check
  logic          eop;
  logic          at_last;

  assign eop          = req.end_of_op && desc_valid;  // only seen while valid
  assign at_last      = (idx_q == cfg.last_index[IW-1:0]);
  assign active_index = desc_idx_t'(idx_q);

  ////////////////////////////////////////
  // index walk
  ////////////////////////////////////////
  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      idx_q  <= '0;
      idx_d1 <= '0;
    end else begin
      idx_d1 <= idx_q;
      if (eop) begin
        idx_q <= (idx_q == IW'(NUM_DESC - 1)) ? '0 : idx_q + 1'b1; // wrap at table end
      end
    end
  end

  // stop and error flags
  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      stop  <= 1'b0;
      error <= 1'b0;
    end else if (cfg.clear_stats) begin
      stop  <= 1'b0;
      error <= 1'b0;
    end else begin
      if (eop && at_last) stop  <= 1'b1;    // last descriptor done
      if (req.op_error)   error <= 1'b1;    // sticky
    end
  end

  ////////////////////////////////////////
  // descriptor output
  ////////////////////////////////////////
  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      desc_valid <= 1'b0;
    end else if (eop) begin
      desc_valid <= 1'b0;                   // drop right after end of op
    end else begin
      desc_valid <= cfg.enable && !stop && (idx_q == idx_d1);
    end
  end

  always_ff @(posedge CLK) begin
    desc.addr   <= addr_word;               // port B data, one cycle behind index
    desc.size   <= size_word;
    desc.window <= cfg.window_size;
  end

  // no descriptor is offered once the table end has been reached
  a_no_valid_stopped: assert property (@(posedge CLK) disable iff (!RST_N)
    stop |-> !desc_valid);

endmodule

//--- logic/dma_engine_manager.sv
/*
  DMA engine manager top
  APB register block, descriptor RAMs, sequencer and statistics
*/
`timescale 1ns/1ps

module dma_engine_manager
  import dma_map_pkg::*;
  import dma_types_pkg::*;
#(
  parameter int NUM_DESC = 1024
) (
  input  logic              CLK,
  input  logic              RST_N,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [ADDR_W-1:0] paddr,
  input  logic [DATA_W-1:0] pwdata,
  input  logic [STRB_W-1:0] pstrb,
  output logic [DATA_W-1:0] prdata,
  output logic              pready,
  input  logic [7:0]        control_byte,
  input  logic [63:0]       byte_count,
  output logic [7:0]        status_byte,
  output logic              desc_valid,
  output desc_out_t         desc
);

  engine_cfg_t       cfg;
  desc_host_t        host_wr;
  engine_status_t    status;
  req_status_t       req;
  logic [DATA_W-1:0] addr_rdata;
  logic [DATA_W-1:0] size_rdata;
  desc_ctrl_t        ctrl_rdata;
  logic [63:0]       addr_word;
  logic [63:0]       size_word;
  desc_idx_t         active_index;
  logic              stop;
  logic              error;
  logic              running;
  logic [63:0]       time_count;
  logic [63:0]       byte_total;

  assign req         = '{end_of_op: control_byte[3], op_error: control_byte[4]};
  assign status_byte = status;

  engine_regs #(.NUM_DESC(NUM_DESC)) u_regs (
    .CLK, .RST_N, .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb,
    .prdata, .pready, .cfg, .host_wr, .status,
    .addr_rdata, .size_rdata, .ctrl_rdata, .active_index,
    .stop, .error, .running, .time_count, .byte_total
  );

  ////////////////////////////////////////
  // descriptor field RAMs
  ////////////////////////////////////////
  descriptor_ram #(.word_t(logic [63:0]), .NUM_DESC(NUM_DESC)) u_ram_addr (
    .CLK, .host_index(host_wr.index), .host_we(host_wr.we_addr),
    .host_strb(host_wr.strb), .host_data(host_wr.data), .host_rdata(addr_rdata),
    .seq_index(active_index), .seq_rdata(addr_word)
  );

  descriptor_ram #(.word_t(logic [63:0]), .NUM_DESC(NUM_DESC)) u_ram_size (
    .CLK, .host_index(host_wr.index), .host_we(host_wr.we_size),
    .host_strb(host_wr.strb), .host_data(host_wr.data), .host_rdata(size_rdata),
    .seq_index(active_index), .seq_rdata(size_word)
  );

  descriptor_ram #(.word_t(desc_ctrl_t), .NUM_DESC(NUM_DESC)) u_ram_ctrl (
    .CLK, .host_index(host_wr.index), .host_we(host_wr.we_ctrl),
    .host_strb(host_wr.strb[0]), .host_data(desc_ctrl_t'(host_wr.data[7:0])),
    .host_rdata(ctrl_rdata),
    .seq_index(active_index), .seq_rdata()  // flags stay on the host side
  );

  descriptor_sequencer #(.NUM_DESC(NUM_DESC)) u_seq (
    .CLK, .RST_N, .cfg, .req, .addr_word, .size_word,
    .active_index, .stop, .error, .desc_valid, .desc
  );

  engine_stats u_stats (
    .CLK, .RST_N, .cfg, .stop, .byte_count,
    .running, .time_count, .byte_total
  );

endmodule

//--- logic/dma_map_pkg.sv
/*
  DMA engine address map
  host bus widths, engine register offsets and descriptor table layout
*/
package dma_map_pkg;

  localparam int DATA_W = 64;            // host data width
  localparam int STRB_W = DATA_W / 8;    // one strobe per byte
  localparam int ADDR_W = 16;            // APB word address

  ////////////////////////////////////////
  // engine registers
  ////////////////////////////////////////
  localparam logic [ADDR_W-1:0] ENGINE_BASE = 16'h0200;
  localparam logic [ADDR_W-1:0] REG_CTRL    = 16'd0;   // status byte / control
  localparam logic [ADDR_W-1:0] REG_INDEX   = 16'd1;   // active index above last index
  localparam logic [ADDR_W-1:0] REG_TIME    = 16'd2;   // running cycle count
  localparam logic [ADDR_W-1:0] REG_BYTES   = 16'd3;   // accumulated byte count
  localparam logic [ADDR_W-1:0] REG_WINDOW  = 16'd4;   // window size

  ////////////////////////////////////////
  // descriptor table
  ////////////////////////////////////////
  // table starts on the first stride-aligned word after the window register
  localparam logic [ADDR_W-1:0] DESC_BASE   = 16'h0208;
  localparam int                DESC_STRIDE = 4;       // words per descriptor
  localparam logic [1:0]        FLD_ADDR    = 2'd0;
  localparam logic [1:0]        FLD_SIZE    = 2'd1;
  localparam logic [1:0]        FLD_CTRL    = 2'd2;    // offset 3 reads zero

  localparam logic [63:0] DEFAULT_WINDOW = 64'd4;

endpackage

//--- logic/dma_types_pkg.sv
/*
  DMA engine types
  packed structs carried between the register, RAM, sequencer and stats blocks
*/
package dma_types_pkg;
  import dma_map_pkg::*;

  typedef logic [15:0] desc_idx_t;   // low clog2(NUM_DESC) bits used
  typedef logic [7:0]  desc_ctrl_t;  // host flag byte per descriptor

  typedef struct packed {
    logic        enable;
    logic        clear_stats;        // one cycle pulse
    logic [1:0]  capabilities;
    desc_idx_t   last_index;
    logic [63:0] window_size;
  } engine_cfg_t;

  // status byte, msb first
  typedef struct packed {
    logic       zero;
    logic [1:0] capabilities;
    logic       error;
    logic       stop;
    logic       running;
    logic       reset_pulse;
    logic       enable;
  } engine_status_t;

  typedef struct packed {
    logic end_of_op;                 // control byte bit 3
    logic op_error;                  // control byte bit 4
  } req_status_t;

  typedef struct packed {
    desc_idx_t         index;
    logic [STRB_W-1:0] strb;
    logic [DATA_W-1:0] data;
    logic              we_addr;
    logic              we_size;
    logic              we_ctrl;
  } desc_host_t;

  typedef struct packed {
    logic [63:0] addr;
    logic [63:0] size;
    logic [63:0] window;
  } desc_out_t;

endpackage

//--- logic/engine_regs.sv
/*
  engine register block
  APB slave with one wait state, engine control registers,
  descriptor field write decode and the host read mux
*/
`timescale 1ns/1ps

module engine_regs
  import dma_map_pkg::*;
  import dma_types_pkg::*;
#(
  parameter int NUM_DESC = 1024
) (
  input  logic              CLK,
  input  logic              RST_N,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [ADDR_W-1:0] paddr,
  input  logic [DATA_W-1:0] pwdata,
  input  logic [STRB_W-1:0] pstrb,
  output logic [DATA_W-1:0] prdata,
  output logic              pready,
  output engine_cfg_t       cfg,
  output desc_host_t        host_wr,
  output engine_status_t    status,
  input  logic [DATA_W-1:0] addr_rdata,
  input  logic [DATA_W-1:0] size_rdata,
  input  desc_ctrl_t        ctrl_rdata,
  input  desc_idx_t         active_index,
  input  logic              stop,
  input  logic              error,
  input  logic              running,
  input  logic [63:0]       time_count,
  input  logic [63:0]       byte_total
);

  localparam int          FW         = $clog2(DESC_STRIDE);
  localparam logic [31:0] DESC_WORDS = 32'(NUM_DESC * DESC_STRIDE);

  logic              enable_q;
  logic              reset_q;     // reset pulse, also clears stats
  logic [1:0]        caps_q;
  desc_idx_t         last_q;
  logic [63:0]       window_q;
  logic              wr_fire;
  logic [ADDR_W-1:0] desc_off;
  logic              desc_hit;
  logic [FW-1:0]     fld;

  ////////////////////////////////////////
  // APB handshake and decode
  ////////////////////////////////////////
  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      pready <= 1'b0;
    end else begin
      pready <= psel && penable && !pready; // high on 2nd access cycle
    end
  end

  assign wr_fire  = psel && penable && pwrite && pready; // write lands here
  assign desc_off = paddr - DESC_BASE;
  assign desc_hit = (paddr >= DESC_BASE) && (32'(desc_off) < DESC_WORDS);
  assign fld      = desc_off[FW-1:0];                    // field within descriptor

  always_comb begin
    host_wr.index   = desc_off >> FW;  // port A address, reads too
    host_wr.strb    = pstrb;
    host_wr.data    = pwdata;
    host_wr.we_addr = wr_fire && desc_hit && (fld == FLD_ADDR);
    host_wr.we_size = wr_fire && desc_hit && (fld == FLD_SIZE);
    host_wr.we_ctrl = wr_fire && desc_hit && (fld == FLD_CTRL);
  end

  ////////////////////////////////////////
  // engine registers
  ////////////////////////////////////////
  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      enable_q <= 1'b0;
      reset_q  <= 1'b0;
      caps_q   <= 2'b00;
      last_q   <= '0;
      window_q <= DEFAULT_WINDOW;
    end else begin
      reset_q <= 1'b0;                        // self clearing
      if (stop && !reset_q) begin
        enable_q <= 1'b0;                     // engine halts at stop
      end
      if (wr_fire) begin
        case (paddr)
          ENGINE_BASE + REG_CTRL: begin
            if (pstrb[0]) begin
              caps_q   <= pwdata[3:2];
              reset_q  <= pwdata[1];
              enable_q <= pwdata[0];
            end
          end
          ENGINE_BASE + REG_INDEX: begin
            for (int b = 0; b < $bits(desc_idx_t) / 8; b++) begin
              if (pstrb[b]) last_q[b*8 +: 8] <= pwdata[b*8 +: 8];
            end
          end
          ENGINE_BASE + REG_WINDOW: begin
            for (int b = 0; b < STRB_W; b++) begin
              if (pstrb[b]) window_q[b*8 +: 8] <= pwdata[b*8 +: 8];
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  assign cfg = '{enable:       enable_q,
                 clear_stats:  reset_q,
                 capabilities: caps_q,
                 last_index:   last_q,
                 window_size:  window_q};

  assign status = '{zero:         1'b0,
                    capabilities: caps_q,
                    error:        error,
                    stop:         stop,
                    running:      running,
                    reset_pulse:  reset_q,
                    enable:       enable_q};

  ////////////////////////////////////////
  // read mux
  ////////////////////////////////////////
  always_comb begin
    prdata = '0;
    if (desc_hit) begin
      case (fld)
        FLD_ADDR: prdata = addr_rdata;
        FLD_SIZE: prdata = size_rdata;
        FLD_CTRL: prdata = DATA_W'(ctrl_rdata);
        default:  prdata = '0;                  // unused slot
      endcase
    end else begin
      case (paddr)
        ENGINE_BASE + REG_CTRL:   prdata = DATA_W'(status);
        ENGINE_BASE + REG_INDEX:  prdata = DATA_W'({active_index, last_q});
        ENGINE_BASE + REG_TIME:   prdata = time_count;
        ENGINE_BASE + REG_BYTES:  prdata = byte_total;
        ENGINE_BASE + REG_WINDOW: prdata = window_q;
        default:                  prdata = '0;  // unmapped
      endcase
    end
  end

  // master must hold the access phase until the wait state ends
  a_pready_access: assert property (@(posedge CLK) disable iff (!RST_N)
    pready |-> psel && penable);

endmodule

//--- logic/engine_stats.sv
/*
  engine statistics
  running flag, cycle counter and byte accumulator
*/
`timescale 1ns/1ps

module engine_stats
  import dma_types_pkg::*;
(
  input  logic        CLK,
  input  logic        RST_N,
  input  engine_cfg_t cfg,
  input  logic        stop,
  input  logic [63:0] byte_count,
  output logic        running,
  output logic [63:0] time_count,
  output logic [63:0] byte_total
);

  logic active;

  assign active = cfg.enable && !stop;  // counting window

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      running    <= 1'b0;
      time_count <= '0;
      byte_total <= '0;
    end else begin
      running <= active;
      if (cfg.clear_stats) begin
        time_count <= '0;
        byte_total <= '0;
      end else if (active) begin
        time_count <= time_count + 64'd1;        // cycles
        byte_total <= byte_total + byte_count;   // requester bytes per cycle
      end
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the DMA engine manager testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f list.f --top-module tb_dma_engine_manager \
  -o tb_dma_engine_manager

./obj_dir/tb_dma_engine_manager 2>&1 | tee sim.log

if grep -qx "sim passed" sim.log; then
  echo "run_sim: testbench reported success"
else
  echo "run_sim: testbench reported failure"
  exit 1
fi

//--- tests/tb_clock_gen.sv
/*
  testbench clock source
  free running clock, 4 ns period
*/
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter realtime HALF_PERIOD = 2.0  // ns
) (
  output logic clk
);

  initial begin
    clk = 1'b0;  // known level at time zero
  end

  always #(HALF_PERIOD) clk = ~clk;

endmodule

//--- tests/tb_dma_engine_manager.sv
/*
  DMA engine manager testbench
  APB programming of the descriptor table, descriptor walk against a model,
  stop, error and statistics checks
*/
`timescale 1ns/1ps

module tb_dma_engine_manager
  import dma_map_pkg::*;
  import dma_types_pkg::*;
();

  localparam int NUM_DESC = 16;
  localparam int SEED     = 45334;
  localparam int LIMIT    = 200;          // cycles per wait loop

  logic              clk;
  logic              RST_N;
  logic              psel, penable, pwrite;
  logic [ADDR_W-1:0] paddr;
  logic [DATA_W-1:0] pwdata;
  logic [STRB_W-1:0] pstrb;
  logic [DATA_W-1:0] prdata;
  logic              pready;
  logic [7:0]        control_byte;
  logic [63:0]       byte_count;
  logic [7:0]        status_byte;
  logic              desc_valid;
  desc_out_t         desc;

  logic [63:0] m_addr [NUM_DESC];         // model of the descriptor table
  logic [63:0] m_size [NUM_DESC];
  logic [7:0]  m_ctrl [NUM_DESC];
  int          err_count;
  int          timeout_count;

  tb_clock_gen u_clk (.clk(clk));

  dma_engine_manager #(.NUM_DESC(NUM_DESC)) UUT (
    .CLK(clk), .RST_N, .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb,
    .prdata, .pready, .control_byte, .byte_count, .status_byte,
    .desc_valid, .desc
  );

  ////////////////////////////////////////
  // reporting
  ////////////////////////////////////////
  task automatic finish_run();
    $display("run summary: %0d errors, %0d timeouts", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  task automatic timeout_stop(input string what);
    $display("timeout: %s did not happen within %0d cycles", what, LIMIT);
    timeout_count++;
    finish_run();
  endtask

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      err_count++;
    end
  endtask

  ////////////////////////////////////////
  // APB master with one transfer per call
  ////////////////////////////////////////
  task automatic apb_transfer(input logic wr, input logic [ADDR_W-1:0] addr,
                              input logic [63:0] data, input logic [7:0] strb,
                              output logic [63:0] rdata);
    int cnt;
    cnt = 0;
    @(negedge clk);
    psel    = 1'b1;                       // setup phase
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    pstrb   = strb;
    @(negedge clk);
    penable = 1'b1;                       // access phase
    while (!pready && cnt < LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (cnt >= LIMIT) timeout_stop("pready");
    rdata = prdata;                       // stable with pready
    @(negedge clk);                       // write lands on this edge
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [63:0] data,
                           input logic [7:0] strb);
    logic [63:0] unused;
    apb_transfer(1'b1, addr, data, strb, unused);
  endtask

  task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [63:0] data);
    apb_transfer(1'b0, addr, 64'd0, 8'h00, data);
  endtask

  ////////////////////////////////////////
  // requester side and helpers
  ////////////////////////////////////////
  task automatic wait_desc_valid();
    int cnt;
    cnt = 0;
    while (!desc_valid && cnt < LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (cnt >= LIMIT) timeout_stop("desc_valid");
  endtask

  // one cycle report on the control byte from a falling edge
  task automatic pulse_control(input logic [7:0] value);
    control_byte = value;
    @(negedge clk);
    control_byte = 8'h00;
  endtask

  function automatic logic [ADDR_W-1:0] field_addr(input int idx, input int fld);
    return ADDR_W'(DESC_BASE + idx * DESC_STRIDE + fld);
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_val,
                                              input logic [63:0] new_val,
                                              input logic [7:0] strb);
    logic [63:0] res;
    res = old_val;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) res[b*8 +: 8] = new_val[b*8 +: 8];
    end
    return res;
  endfunction

  // status byte from the top bit down is zero caps error stop running pulse enable
  function automatic logic [63:0] status_value(input logic [1:0] caps, input logic err,
                                               input logic stp, input logic run,
                                               input logic en);
    return 64'({1'b0, caps, err, stp, run, 1'b0, en});
  endfunction

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    logic [63:0] rd, data, window, b_const, time_val, bytes_val;
    logic [7:0]  strb;
    logic [1:0]  caps;
    int          idx, fld, last_idx, model_idx;
    bit          stopped;

    err_count     = 0;
    timeout_count = 0;
    void'($urandom(SEED));
    RST_N        = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    pstrb        = '0;
    control_byte = 8'h00;
    byte_count   = 64'd0;
    repeat (5) @(negedge clk);
    RST_N = 1'b1;

    // reset state
    check("reset status byte", 64'd0, 64'(status_byte));
    check("reset desc_valid", 64'd0, 64'(desc_valid));
    apb_read(ENGINE_BASE + REG_WINDOW, rd);
    check("reset window", 64'd4, rd);
    apb_read(ENGINE_BASE + REG_CTRL, rd);
    check("reset status reg", 64'd0, rd);

    // fill the table and apply random strobed updates
    for (int i = 0; i < NUM_DESC; i++) begin
      m_addr[i] = {$urandom, $urandom};
      m_size[i] = {$urandom, $urandom};
      m_ctrl[i] = 8'($urandom);
      apb_write(field_addr(i, 0), m_addr[i], 8'hff);
      apb_write(field_addr(i, 1), m_size[i], 8'hff);
      apb_write(field_addr(i, 2), 64'(m_ctrl[i]), 8'hff);
    end
    for (int n = 0; n < 40; n++) begin
      idx  = $urandom_range(NUM_DESC - 1, 0);
      fld  = $urandom_range(2, 0);
      data = {$urandom, $urandom};
      strb = 8'($urandom);
      apb_write(field_addr(idx, fld), data, strb);
      case (fld)
        0:       m_addr[idx] = merge_bytes(m_addr[idx], data, strb);
        1:       m_size[idx] = merge_bytes(m_size[idx], data, strb);
        default: if (strb[0]) m_ctrl[idx] = data[7:0];  // one byte field
      endcase
    end
    for (int i = 0; i < NUM_DESC; i++) begin
      apb_read(field_addr(i, 0), rd);
      check("readback addr", m_addr[i], rd);
      apb_read(field_addr(i, 1), rd);
      check("readback size", m_size[i], rd);
      apb_read(field_addr(i, 2), rd);
      check("readback ctrl", 64'(m_ctrl[i]), rd);
      apb_read(field_addr(i, 3), rd);
      check("readback slot 3", 64'd0, rd);
    end

    // program and run the walk
    last_idx = $urandom_range(NUM_DESC - 1, 8);
    window   = {$urandom, $urandom};
    caps     = 2'($urandom);
    b_const  = 64'($urandom_range(4096, 1));
    apb_write(ENGINE_BASE + REG_INDEX, 64'(last_idx), 8'h03);
    apb_write(ENGINE_BASE + REG_WINDOW, window, 8'hff);
    byte_count = b_const;                 // held for the whole run
    apb_write(ENGINE_BASE + REG_CTRL, 64'({caps, 1'b0, 1'b1}), 8'h01);
    model_idx = 0;
    stopped   = 1'b0;
    while (!stopped) begin
      wait_desc_valid();
      check("desc addr", m_addr[model_idx], desc.addr);
      check("desc size", m_size[model_idx], desc.size);
      check("desc window", window, desc.window);
      check("running status", status_value(caps, 1'b0, 1'b0, 1'b1, 1'b1), 64'(status_byte));
      pulse_control(8'h08);               // end of op
      if (model_idx == last_idx) stopped = 1'b1;
      model_idx = (model_idx + 1) % NUM_DESC;
    end

    // stopped at the last index
    apb_read(ENGINE_BASE + REG_CTRL, rd);
    check("stop status reg", status_value(caps, 1'b0, 1'b1, 1'b0, 1'b0), rd);
    check("stop status byte", status_value(caps, 1'b0, 1'b1, 1'b0, 1'b0),
          64'(status_byte));
    apb_read(ENGINE_BASE + REG_INDEX, rd);
    check("index reg", 64'({16'(model_idx), 16'(last_idx)}), rd);
    for (int n = 0; n < 8; n++) begin
      @(negedge clk);
      check("valid after stop", 64'd0, 64'(desc_valid));
    end

    // counters
    apb_read(ENGINE_BASE + REG_TIME, time_val);
    apb_read(ENGINE_BASE + REG_BYTES, bytes_val);
    check("time nonzero", 64'd1, 64'(time_val != 0));
    check("bytes nonzero", 64'd1, 64'(bytes_val != 0));
    check("bytes per cycle", b_const * time_val, bytes_val);

    // error report and clear through the control reset bit
    @(negedge clk);
    pulse_control(8'h10);                 // op error
    apb_read(ENGINE_BASE + REG_CTRL, rd);
    check("error status reg", status_value(caps, 1'b1, 1'b1, 1'b0, 1'b0), rd);
    apb_write(ENGINE_BASE + REG_CTRL, 64'h2, 8'h01);
    apb_read(ENGINE_BASE + REG_CTRL, rd);
    check("cleared status reg", 64'd0, rd);
    apb_read(ENGINE_BASE + REG_TIME, rd);
    check("cleared time", 64'd0, rd);
    apb_read(ENGINE_BASE + REG_BYTES, rd);
    check("cleared bytes", 64'd0, rd);

    finish_run();
  end

endmodule
